/* rtl/tcdm_pkg.sv */
// TCDM subsystem package with sizes, address fields, bank queue depth and enums
`default_nettype none

package tcdm_pkg;

  localparam int unsigned NumIn         = 4;   // Initiators
  localparam int unsigned NumOut        = 8;   // Banks
  localparam int unsigned NumInLog2     = 2;   // Initiator index width
  localparam int unsigned NumOutLog2    = 3;   // Bank index width
  localparam int unsigned AddrWidth     = 32;  // Initiator address
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned BeWidth       = 4;   // One bit per byte
  localparam int unsigned ByteOffWidth  = 2;   // Byte offset below bank index
  localparam int unsigned AddrMemWidth  = 6;   // 64 words per bank
  // Opcode, byte enables, word address, write data
  localparam int unsigned ReqAggWidth   = 1 + BeWidth + AddrMemWidth + DataWidth;
  localparam int unsigned BankDepth     = 4;   // Pending requests per bank
  localparam int unsigned BankDepthLog2 = 2;
  localparam int unsigned MaxLatency    = 4;   // Smallest latency is 1

  // Per-bank LFSR seeds, never zero
  localparam logic [NumOut-1:0][15:0] LfsrSeed = {
    16'h9e37, 16'h5a5a, 16'h3c1d, 16'hb4e1, 16'h7f13, 16'h2468, 16'hc0de, 16'hace1
  };

  typedef enum logic {OP_READ, OP_WRITE} op_e;

  typedef enum logic [1:0] {BANK_IDLE, BANK_WAIT, BANK_RESP} bank_state_e;

endpackage : tcdm_pkg

`default_nettype wire

/* rtl/rr_arbiter.sv */
// Round-robin arbiter with rotating priority pointer, one-hot grant and winner index
`default_nettype none

module rr_arbiter #(
  parameter int unsigned NumReq = tcdm_pkg::NumIn  // Requester count, power of two
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [NumReq-1:0] req_i,  // Pending requests
  input  logic              ack_i,  // Granted transfer completed
  output logic [NumReq-1:0] gnt_o,  // One-hot grant
  // Index width picked from the package by requester count
  output logic [(NumReq > tcdm_pkg::NumIn ? tcdm_pkg::NumOutLog2
                                          : tcdm_pkg::NumInLog2)-1:0] idx_o
);

  logic [$bits(idx_o)-1:0] ptr_q;  // Highest priority requester
  logic [$bits(idx_o)-1:0] cand;
  logic                    found;

  // First requester at or after the pointer, wrapping
  always_comb begin
    idx_o = ptr_q;
    found = 1'b0;
    cand  = ptr_q;
    for (int unsigned k = 0; k < NumReq; k++) begin
      cand = ptr_q + $bits(idx_o)'(k);  // Wraps since NumReq is a power of two
      if (!found && req_i[cand]) begin
        idx_o = cand;
        found = 1'b1;
      end
    end
    gnt_o        = '0;
    gnt_o[idx_o] = found;  // No grant without a request
  end

  // Pointer moves past the winner only on a transfer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (ack_i) begin
      ptr_q <= idx_o + 1'b1;
    end
  end

endmodule : rr_arbiter

`default_nettype wire

/* rtl/full_duplex_xbar.sv */
// Full crossbar pair routing requests to banks and responses back to initiators
`default_nettype none

module full_duplex_xbar (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  // Initiator side
  input  logic [tcdm_pkg::NumIn-1:0]                             req_valid_i,
  output logic [tcdm_pkg::NumIn-1:0]                             req_ready_o,
  input  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::NumOutLog2-1:0]   req_tgt_addr_i,  // Bank index
  input  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::ReqAggWidth-1:0]  req_wdata_i,     // Packed payload
  output logic [tcdm_pkg::NumIn-1:0]                             resp_valid_o,
  input  logic [tcdm_pkg::NumIn-1:0]                             resp_ready_i,
  output logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::DataWidth-1:0]    resp_rdata_o,
  // Bank side
  output logic [tcdm_pkg::NumOut-1:0]                            req_valid_o,
  input  logic [tcdm_pkg::NumOut-1:0]                            req_ready_i,
  output logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::NumInLog2-1:0]   req_ini_addr_o,
  output logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::ReqAggWidth-1:0] req_wdata_o,
  input  logic [tcdm_pkg::NumOut-1:0]                            resp_valid_i,
  output logic [tcdm_pkg::NumOut-1:0]                            resp_ready_o,
  input  logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::NumInLog2-1:0]   resp_ini_addr_i,
  input  logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::DataWidth-1:0]   resp_rdata_i
);

  import tcdm_pkg::*;

  logic [NumOut-1:0][NumIn-1:0]   req_vec;   // Per bank, initiators aiming at it
  logic [NumOut-1:0][NumIn-1:0]   req_gnt;
  logic [NumIn-1:0][NumOut-1:0]   resp_vec;  // Per initiator, banks answering it
  logic [NumIn-1:0][NumOut-1:0]   resp_gnt;
  logic [NumIn-1:0][NumOutLog2-1:0] resp_idx;  // Winning bank per initiator

  // Request path
  for (genvar j = 0; j < NumOut; j++) begin : gen_req_bank
    for (genvar i = 0; i < NumIn; i++) begin : gen_req_dec
      assign req_vec[j][i] = req_valid_i[i] & (req_tgt_addr_i[i] == NumOutLog2'(j));
    end

    rr_arbiter #(
      .NumReq(NumIn)
    ) i_req_arb (
      .clk_i  (clk_i                          ),
      .rst_n_i(rst_n_i                        ),
      .req_i  (req_vec[j]                     ),
      .ack_i  (req_valid_o[j] & req_ready_i[j]),
      .gnt_o  (req_gnt[j]                     ),
      .idx_o  (req_ini_addr_o[j]              )  // Winner doubles as initiator index
    );

    assign req_valid_o[j] = |req_vec[j];  // No dependence on ready
    assign req_wdata_o[j] = req_wdata_i[req_ini_addr_o[j]];
  end

  // Ready back to initiator only when its bank grants it
  for (genvar i = 0; i < NumIn; i++) begin : gen_req_ready
    assign req_ready_o[i] = req_ready_i[req_tgt_addr_i[i]]
                          & req_gnt[req_tgt_addr_i[i]][i];
  end

  // Response path
  for (genvar i = 0; i < NumIn; i++) begin : gen_resp_ini
    for (genvar j = 0; j < NumOut; j++) begin : gen_resp_dec
      assign resp_vec[i][j] = resp_valid_i[j] & (resp_ini_addr_i[j] == NumInLog2'(i));
    end

    rr_arbiter #(
      .NumReq(NumOut)
    ) i_resp_arb (
      .clk_i  (clk_i                            ),
      .rst_n_i(rst_n_i                          ),
      .req_i  (resp_vec[i]                      ),
      .ack_i  (resp_valid_o[i] & resp_ready_i[i]),
      .gnt_o  (resp_gnt[i]                      ),
      .idx_o  (resp_idx[i]                      )
    );

    assign resp_valid_o[i] = |resp_vec[i];
    assign resp_rdata_o[i] = resp_rdata_i[resp_idx[i]];
  end

  // Bank sees ready only while the addressed initiator grants it
  for (genvar j = 0; j < NumOut; j++) begin : gen_resp_ready
    assign resp_ready_o[j] = resp_ready_i[resp_ini_addr_i[j]]
                           & resp_gnt[resp_ini_addr_i[j]][j];
  end

endmodule : full_duplex_xbar

`default_nettype wire

/* rtl/variable_latency_interconnect.sv */
// Interconnect splitting addresses into bank and word, packing payload around the crossbar
`default_nettype none

module variable_latency_interconnect (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  // Initiator side
  input  logic [tcdm_pkg::NumIn-1:0]                              req_valid_i,
  output logic [tcdm_pkg::NumIn-1:0]                              req_ready_o,
  input  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::AddrWidth-1:0]     req_addr_i,
  input  logic [tcdm_pkg::NumIn-1:0]                              req_wen_i,
  input  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::DataWidth-1:0]     req_wdata_i,
  input  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::BeWidth-1:0]       req_be_i,
  output logic [tcdm_pkg::NumIn-1:0]                              resp_valid_o,
  input  logic [tcdm_pkg::NumIn-1:0]                              resp_ready_i,
  output logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::DataWidth-1:0]     resp_rdata_o,
  // Bank side
  output logic [tcdm_pkg::NumOut-1:0]                             req_valid_o,
  input  logic [tcdm_pkg::NumOut-1:0]                             req_ready_i,
  output logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::NumInLog2-1:0]    req_ini_addr_o,
  output logic [tcdm_pkg::NumOut-1:0]                             req_wen_o,
  output logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::BeWidth-1:0]      req_be_o,
  output logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::AddrMemWidth-1:0] req_word_addr_o,
  output logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::DataWidth-1:0]    req_wdata_o,
  input  logic [tcdm_pkg::NumOut-1:0]                             resp_valid_i,
  output logic [tcdm_pkg::NumOut-1:0]                             resp_ready_o,
  input  logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::NumInLog2-1:0]    resp_ini_addr_i,
  input  logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::DataWidth-1:0]    resp_rdata_i
);

  import tcdm_pkg::*;

  logic [NumIn-1:0][NumOutLog2-1:0]   tgt_sel;   // Bank index per initiator
  logic [NumIn-1:0][ReqAggWidth-1:0]  agg_in;
  logic [NumOut-1:0][ReqAggWidth-1:0] agg_out;

  for (genvar i = 0; i < NumIn; i++) begin : gen_pack
    assign tgt_sel[i] = req_addr_i[i][ByteOffWidth +: NumOutLog2];  // Word interleaving
    // Upper address bits above the word field are dropped
    assign agg_in[i]  = {req_wen_i[i], req_be_i[i],
                         req_addr_i[i][ByteOffWidth + NumOutLog2 +: AddrMemWidth],
                         req_wdata_i[i]};
  end

  for (genvar j = 0; j < NumOut; j++) begin : gen_unpack
    assign {req_wen_o[j], req_be_o[j], req_word_addr_o[j], req_wdata_o[j]} = agg_out[j];
  end

  full_duplex_xbar i_xbar (
    .clk_i          (clk_i          ),
    .rst_n_i        (rst_n_i        ),
    .req_valid_i    (req_valid_i    ),
    .req_ready_o    (req_ready_o    ),
    .req_tgt_addr_i (tgt_sel        ),
    .req_wdata_i    (agg_in         ),
    .resp_valid_o   (resp_valid_o   ),
    .resp_ready_i   (resp_ready_i   ),
    .resp_rdata_o   (resp_rdata_o   ),
    .req_valid_o    (req_valid_o    ),
    .req_ready_i    (req_ready_i    ),
    .req_ini_addr_o (req_ini_addr_o ),
    .req_wdata_o    (agg_out        ),
    .resp_valid_i   (resp_valid_i   ),
    .resp_ready_o   (resp_ready_o   ),
    .resp_ini_addr_i(resp_ini_addr_i),
    .resp_rdata_i   (resp_rdata_i   )
  );

endmodule : variable_latency_interconnect

`default_nettype wire

/* rtl/tcdm_bank.sv */
// Memory bank answering each request in order after an LFSR-drawn latency
`default_nettype none

module tcdm_bank #(
  parameter int unsigned BankIdx = 0  // Selects the LFSR seed
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  logic [tcdm_pkg::NumInLog2-1:0]    req_ini_addr_i,
  input  logic                              req_wen_i,
  input  logic [tcdm_pkg::BeWidth-1:0]      req_be_i,
  input  logic [tcdm_pkg::AddrMemWidth-1:0] req_word_addr_i,
  input  logic [tcdm_pkg::DataWidth-1:0]    req_wdata_i,
  output logic                              resp_valid_o,
  input  logic                              resp_ready_i,
  output logic [tcdm_pkg::NumInLog2-1:0]    resp_ini_addr_o,
  output logic [tcdm_pkg::DataWidth-1:0]    resp_rdata_o
);

  import tcdm_pkg::*;

  logic [DataWidth-1:0]     mem_q [2**AddrMemWidth];  // Bank storage
  logic [NumInLog2-1:0]     ini_q [BankDepth];        // Queue, requesting initiator
  logic [DataWidth-1:0]     data_q [BankDepth];       // Queue, result word
  logic [BankDepthLog2-1:0] wr_ptr_q, rd_ptr_q;
  logic [BankDepthLog2:0]   cnt_q;                    // Entries held, 0 to BankDepth
  logic [15:0]              lfsr_q;
  logic [$clog2(MaxLatency)-1:0] lat_q;               // Remaining wait minus one
  bank_state_e              state_q;
  op_e                      req_op;
  logic [DataWidth-1:0]     merged;                   // Memory word after byte merge
  logic                     req_fire, resp_fire;

  assign req_op       = op_e'(req_wen_i);
  assign req_ready_o  = (cnt_q != (BankDepthLog2 + 1)'(BankDepth));  // Low only when full
  assign req_fire     = req_valid_i & req_ready_o;
  assign resp_valid_o = (state_q == BANK_RESP);
  assign resp_fire    = resp_valid_o & resp_ready_i;
  assign resp_ini_addr_o = ini_q[rd_ptr_q];  // Head entry
  assign resp_rdata_o    = data_q[rd_ptr_q];

  // Byte-enable merge, reads keep the stored word
  always_comb begin
    merged = mem_q[req_word_addr_i];
    if (req_op == OP_WRITE) begin
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (req_be_i[b]) merged[8*b +: 8] = req_wdata_i[8*b +: 8];
      end
    end
  end

  // Memory and queue payload
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req_op == OP_WRITE) mem_q[req_word_addr_i] <= merged;
      ini_q[wr_ptr_q]  <= req_ini_addr_i;
      data_q[wr_ptr_q] <= merged;  // Merged word for writes too
    end
  end

  // Queue pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (req_fire)  wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at BankDepth
      if (resp_fire) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({req_fire, resp_fire})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // Both or neither
      endcase
    end
  end

  // Free-running Fibonacci LFSR, taps 16 14 13 11
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q <= LfsrSeed[BankIdx];
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    end
  end

  // Output stage paces the head entry
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= BANK_IDLE;
      lat_q   <= '0;
    end else begin
      unique case (state_q)
        BANK_IDLE: begin
          if (cnt_q != '0) begin
            lat_q   <= lfsr_q[$clog2(MaxLatency)-1:0];  // Wait of 1 to MaxLatency
            state_q <= BANK_WAIT;
          end
        end
        BANK_WAIT: begin
          if (lat_q == '0) state_q <= BANK_RESP;
          else             lat_q   <= lat_q - 1'b1;
        end
        BANK_RESP: begin
          if (resp_ready_i) state_q <= BANK_IDLE;  // Held until taken
        end
        default: state_q <= BANK_IDLE;
      endcase
    end
  end

endmodule : tcdm_bank

`default_nettype wire

/* rtl/tcdm_subsystem_top.sv */
// TCDM subsystem top joining the interconnect to eight word-interleaved banks
`default_nettype none

module tcdm_subsystem_top (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic [tcdm_pkg::NumIn-1:0]                          req_valid_i,
  output logic [tcdm_pkg::NumIn-1:0]                          req_ready_o,
  input  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::AddrWidth-1:0] req_addr_i,
  input  logic [tcdm_pkg::NumIn-1:0]                          req_wen_i,
  input  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::DataWidth-1:0] req_wdata_i,
  input  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::BeWidth-1:0]   req_be_i,
  output logic [tcdm_pkg::NumIn-1:0]                          resp_valid_o,
  input  logic [tcdm_pkg::NumIn-1:0]                          resp_ready_i,
  output logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::DataWidth-1:0] resp_rdata_o
);

  import tcdm_pkg::*;

  // Interconnect to bank wires
  logic [NumOut-1:0]                   req_valid, req_ready, req_wen;
  logic [NumOut-1:0][NumInLog2-1:0]    req_ini_addr, resp_ini_addr;
  logic [NumOut-1:0][BeWidth-1:0]      req_be;
  logic [NumOut-1:0][AddrMemWidth-1:0] req_word_addr;
  logic [NumOut-1:0][DataWidth-1:0]    req_wdata, resp_rdata;
  logic [NumOut-1:0]                   resp_valid, resp_ready;

  variable_latency_interconnect i_interco (
    .clk_i          (clk_i        ),
    .rst_n_i        (rst_n_i      ),
    .req_valid_i    (req_valid_i  ),
    .req_ready_o    (req_ready_o  ),
    .req_addr_i     (req_addr_i   ),
    .req_wen_i      (req_wen_i    ),
    .req_wdata_i    (req_wdata_i  ),
    .req_be_i       (req_be_i     ),
    .resp_valid_o   (resp_valid_o ),
    .resp_ready_i   (resp_ready_i ),
    .resp_rdata_o   (resp_rdata_o ),
    .req_valid_o    (req_valid    ),
    .req_ready_i    (req_ready    ),
    .req_ini_addr_o (req_ini_addr ),
    .req_wen_o      (req_wen      ),
    .req_be_o       (req_be       ),
    .req_word_addr_o(req_word_addr),
    .req_wdata_o    (req_wdata    ),
    .resp_valid_i   (resp_valid   ),
    .resp_ready_o   (resp_ready   ),
    .resp_ini_addr_i(resp_ini_addr),
    .resp_rdata_i   (resp_rdata   )
  );

  for (genvar k = 0; k < NumOut; k++) begin : gen_banks
    tcdm_bank #(
      .BankIdx(k)  // Distinct LFSR seed per bank
    ) i_bank (
      .clk_i          (clk_i           ),
      .rst_n_i        (rst_n_i         ),
      .req_valid_i    (req_valid[k]    ),
      .req_ready_o    (req_ready[k]    ),
      .req_ini_addr_i (req_ini_addr[k] ),
      .req_wen_i      (req_wen[k]      ),
      .req_be_i       (req_be[k]       ),
      .req_word_addr_i(req_word_addr[k]),
      .req_wdata_i    (req_wdata[k]    ),
      .resp_valid_o   (resp_valid[k]   ),
      .resp_ready_i   (resp_ready[k]   ),
      .resp_ini_addr_o(resp_ini_addr[k]),
      .resp_rdata_o   (resp_rdata[k]   )
    );
  end

endmodule : tcdm_subsystem_top

`default_nettype wire

/* verif/tb_tcdm_subsystem.sv */
// Testbench for the TCDM subsystem with random traffic checked against a memory model
`default_nettype none

module tb_tcdm_subsystem;

  timeunit 1ns;
  timeprecision 1ps;

  import tcdm_pkg::*;

  localparam int unsigned ClkPeriod     = 40;
  localparam int unsigned ReqsPerIni    = 300;
  localparam int unsigned RandomReqs    = 240;  // Remainder goes to the contention phase
  localparam int unsigned MaxInFlight   = 4;    // Per initiator
  localparam logic [NumOutLog2-1:0] ContendBank = 3'd5;
  // Four cycles per request with generous slack
  localparam int unsigned TimeoutCycles = ReqsPerIni * 4 * 40;
  localparam int unsigned ModelWords    = NumOut * (2 ** AddrMemWidth);
  // Idle cycle, longest wait and the response cycle of one stray entry
  localparam int unsigned DrainCycles   = MaxLatency + 2;

  logic                             clk_i;
  logic                             rst_n_i;
  logic [NumIn-1:0]                 req_valid_i;
  logic [NumIn-1:0]                 req_ready_o;
  logic [NumIn-1:0][AddrWidth-1:0]  req_addr_i;
  logic [NumIn-1:0]                 req_wen_i;
  logic [NumIn-1:0][DataWidth-1:0]  req_wdata_i;
  logic [NumIn-1:0][BeWidth-1:0]    req_be_i;
  logic [NumIn-1:0]                 resp_valid_o;
  logic [NumIn-1:0]                 resp_ready_i;
  logic [NumIn-1:0][DataWidth-1:0]  resp_rdata_o;

  logic [31:0]           seed;                     // LCG state
  int unsigned           cycles;
  logic [DataWidth-1:0]  model_mem [ModelWords];   // Indexed by {bank, word}
  bit                    model_known [ModelWords]; // Word written at least once
  logic [DataWidth-1:0]  exp_q [NumIn][$];         // Expected responses per initiator
  logic [NumOutLog2-1:0] cur_bank [NumIn];
  int unsigned           issued [NumIn];
  int unsigned           waits [NumIn];            // Other transfers while waiting
  logic [NumIn-1:0]      fired;                    // Request transfers at the coming edge

  tcdm_subsystem_top dut0 (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .req_addr_i  (req_addr_i  ),
    .req_wen_i   (req_wen_i   ),
    .req_wdata_i (req_wdata_i ),
    .req_be_i    (req_be_i    ),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .resp_rdata_o(resp_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Halves swapped so the low bits come from the better upper LCG bits
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {seed[15:0], seed[31:16]};
  endfunction

  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_word,
                                                       input logic [DataWidth-1:0] new_word,
                                                       input logic [BeWidth-1:0]   be);
    logic [DataWidth-1:0] res;
    res = old_word;
    for (int unsigned b = 0; b < BeWidth; b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];  // Enabled byte replaced
    end
    return res;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("error at %0d ns: %s is 0x%08h, expected 0x%08h",
                               $time, name, actual, expected));
    end
  endtask

  // New request, held on the port until it transfers
  task automatic issue_request(input int i, input bit contend);
    logic [31:0]             r;
    logic [31:0]             r2;
    logic [NumOutLog2-1:0]   bank;
    logic [AddrMemWidth-1:0] word;
    logic                    wen;
    logic [BeWidth-1:0]      be;
    r  = next_rand();
    r2 = next_rand();
    if (contend) cur_bank[i] = ContendBank;
    else if (exp_q[i].size() == 0) cur_bank[i] = r[2:0];  // Nothing pending, may move
    bank = cur_bank[i];
    word = {r[6:3], NumInLog2'(i)};  // Private words of this initiator
    wen  = r[7];
    be   = r[11:8];
    if (!model_known[{bank, word}]) begin
      wen = 1'b1;  // First touch is a full write
      be  = '1;
    end
    req_valid_i[i] = 1'b1;
    req_addr_i[i]  = {r2[20:0], word, bank, r2[22:21]};  // Upper bits are don't care
    req_wen_i[i]   = wen;
    req_be_i[i]    = be;
    req_wdata_i[i] = next_rand();
  endtask

  task automatic drive_inputs(input bit contend, input int unsigned target);
    logic [31:0] r;
    for (int i = 0; i < NumIn; i++) begin
      r = next_rand();
      if (fired[i]) req_valid_i[i] = 1'b0;
      if (!req_valid_i[i] && issued[i] < target && exp_q[i].size() < MaxInFlight
          && (contend || r[1:0] != 2'd0)) begin
        issue_request(i, contend);
      end
      resp_ready_i[i] = (r[19:10] >= 10'd307);  // Low about 30 percent
    end
  endtask

  // Runs at the falling edge, where all DUT outputs have settled
  task automatic sample_outputs(input bit contend);
    logic [NumOutLog2-1:0]   bank;
    logic [AddrMemWidth-1:0] word;
    logic [DataWidth-1:0]    expected;
    for (int i = 0; i < NumIn; i++) begin
      if (resp_valid_o[i] && resp_ready_i[i]) begin
        if (exp_q[i].size() == 0) begin
          report_failure($sformatf("Initiator %0d got a response it never asked for", i));
        end
        expected = exp_q[i].pop_front();
        check_value($sformatf("resp_rdata_o[%0d]", i), resp_rdata_o[i], expected);
      end
    end
    fired = req_valid_i & req_ready_o;
    for (int i = 0; i < NumIn; i++) begin
      if (fired[i]) begin
        bank = req_addr_i[i][4:2];   // Address layout bank field
        word = req_addr_i[i][10:5];  // Word inside the bank
        if (req_wen_i[i]) begin
          model_mem[{bank, word}]   = merge_bytes(model_mem[{bank, word}], req_wdata_i[i],
                                                  req_be_i[i]);
          model_known[{bank, word}] = 1'b1;
        end
        exp_q[i].push_back(model_mem[{bank, word}]);  // Merged word for writes
        issued[i]++;
      end
    end
    if (contend) begin
      for (int i = 0; i < NumIn; i++) begin
        if (fired[i]) waits[i] = 0;
        else if (req_valid_i[i]) begin
          waits[i] += $countones(fired);  // All traffic hits one bank here
          if (waits[i] > NumIn - 1) begin
            report_failure($sformatf("Initiator %0d was passed over more than %0d times",
                                     i, NumIn - 1));
          end
        end
      end
    end
  endtask

  // Ends once every initiator reached its target and got all responses
  task automatic run_phase(input bit contend, input int unsigned target);
    bit busy;
    busy = 1'b1;
    for (int i = 0; i < NumIn; i++) waits[i] = 0;
    while (busy) begin
      @(posedge clk_i);
      #2;
      drive_inputs(contend, target);
      @(negedge clk_i);
      sample_outputs(contend);
      busy = 1'b0;
      for (int i = 0; i < NumIn; i++) begin
        if (issued[i] < target || exp_q[i].size() != 0) busy = 1'b1;
      end
    end
  endtask

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= TimeoutCycles) begin
        report_failure($sformatf("Timeout, run still busy after %0d cycles", cycles));
      end
    end
  end

  initial begin
    seed         = 32'ha801_0135;
    rst_n_i      = 1'b0;
    req_valid_i  = '0;
    req_addr_i   = '0;
    req_wen_i    = '0;
    req_wdata_i  = '0;
    req_be_i     = '0;
    resp_ready_i = '0;
    fired        = '0;
    for (int i = 0; i < NumIn; i++) begin
      cur_bank[i] = '0;
      issued[i]   = 0;
      waits[i]    = 0;
    end
    // No response may show up around reset
    for (int c = 0; c < 16; c++) begin
      @(negedge clk_i);
      check_value("resp_valid_o", 32'(resp_valid_o), 32'd0);
    end
    @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("resp_valid_o", 32'(resp_valid_o), 32'd0);  // First cycle out of reset
    run_phase(1'b0, RandomReqs);
    run_phase(1'b1, ReqsPerIni);  // All initiators on one bank
    // Any late response now has no expected entry and counts as a duplicate
    for (int c = 0; c < DrainCycles; c++) begin
      @(posedge clk_i);
      #2;
      req_valid_i  = '0;
      resp_ready_i = '1;
      @(negedge clk_i);
      sample_outputs(1'b0);
    end
    $display("Test passed");
    $finish;
  end

endmodule : tb_tcdm_subsystem

`default_nettype wire

/* src.f */
rtl/tcdm_pkg.sv
rtl/rr_arbiter.sv
rtl/full_duplex_xbar.sv
rtl/variable_latency_interconnect.sv
rtl/tcdm_bank.sv
rtl/tcdm_subsystem_top.sv
verif/tb_tcdm_subsystem.sv

/* Makefile */
TOP := tb_tcdm_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -f src.f

# The pass line must appear in the simulator output
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir
